// File: Makefile
SRCS := $(shell cat flist.f)
BIN  := obj_dir/Vtb_fabric

.PHONY: all run clean

all: run

$(BIN): $(SRCS) flist.f
	verilator --binary --assert --top-module tb_fabric -f flist.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: clb.sv
`timescale 1ns/100ps

module clb (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           config_en,
    input  logic                           config_in,
    output logic                           config_out,
    input  logic [fabric_pkg::LUT_K-1:0]   clb_in,
    output logic [fabric_pkg::NUM_BLE-1:0] ble_q
);

    import fabric_pkg::*;

    clb_cfg_t           cfg;
    logic [NUM_BLE-1:0] lut_out;

    config_chain #(
        .cfg_t(clb_cfg_t)
    ) u_chain (
        .clk       (clk),
        .reset     (reset),
        .config_en (config_en),
        .config_in (config_in),
        .config_out(config_out),
        .cfg       (cfg)
    );

    // all elements of the block look at the same three pins
    always_comb begin
        for (int e = 0; e < NUM_BLE; e++) begin
            lut_out[e] = cfg[e][clb_in];
        end
    end

    // element outputs are always registered so feedback never forms a loop
    always_ff @(posedge clk) begin
        if (reset) begin
            ble_q <= '0;
        end else begin
            ble_q <= lut_out;
        end
    end

    a_reset_clear: assert property (@(posedge clk) reset |=> ble_q == '0);

endmodule

// File: config_chain.sv
`timescale 1ns/100ps

module config_chain #(
    parameter type cfg_t = logic [7:0]
) (
    input  logic clk,
    input  logic reset,
    input  logic config_en,
    input  logic config_in,
    output logic config_out,
    output cfg_t cfg
);

    logic [$bits(cfg_t)-1:0] shift_q;

    // bits move toward the top while enabled and leave from the msb
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q <= '0;
        end else if (config_en) begin
            shift_q <= {shift_q[$bits(cfg_t)-2:0], config_in};
        end
    end

    assign cfg        = cfg_t'(shift_q);
    assign config_out = shift_q[$bits(cfg_t)-1];

    a_hold_idle: assert property (@(posedge clk)
        !config_en && !reset |=> $stable(cfg));

    a_shift_in: assert property (@(posedge clk)
        config_en && !reset |=> shift_q[0] == $past(config_in));

endmodule

// File: connector_box.sv
`timescale 1ns/100ps

module connector_box (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         config_en,
    input  logic                         config_in,
    output logic                         config_out,
    input  fabric_pkg::track_vec_t       track,
    output logic [fabric_pkg::LUT_K-1:0] clb_in
);

    import fabric_pkg::*;

    cx_cfg_t cfg;

    config_chain #(
        .cfg_t(cx_cfg_t)
    ) u_chain (
        .clk       (clk),
        .reset     (reset),
        .config_en (config_en),
        .config_in (config_in),
        .config_out(config_out),
        .cfg       (cfg)
    );

    always_comb begin
        for (int p = 0; p < LUT_K; p++) begin
            clb_in[p] = track[cfg[p]];   // several pins may share one track
        end
    end

endmodule

// File: fabric_pkg.sv
package fabric_pkg;

    // fabric dimensions
    localparam int NUM_CLB       = 2;
    localparam int NUM_BLE       = 2;               // logic elements per block
    localparam int LUT_K         = 3;
    localparam int CHAN_WIDTH    = 4;               // routing tracks in the channel
    localparam int NUM_PAD_IN    = 4;
    localparam int NUM_PAD_OUT   = 4;
    localparam int NUM_BLE_TOTAL = NUM_CLB * NUM_BLE;

    // track sources are the input pads followed by every element output
    localparam int NUM_TRACK_SRC = NUM_PAD_IN + NUM_BLE_TOTAL;

    localparam int TRACK_SEL_W   = $clog2(NUM_TRACK_SRC);
    localparam int PIN_SEL_W     = $clog2(CHAN_WIDTH);
    localparam int PAD_SEL_W     = $clog2(NUM_BLE_TOTAL);

    typedef logic [NUM_PAD_IN-1:0]    pad_vec_t;
    typedef logic [NUM_BLE_TOTAL-1:0] ble_vec_t;   // clb 0 element 0 in bit 0
    typedef logic [CHAN_WIDTH-1:0]    track_vec_t;

    // one select per output pad, naming an element output
    typedef logic [NUM_PAD_OUT-1:0][PAD_SEL_W-1:0] io_cfg_t;

    // one source select per track
    typedef logic [CHAN_WIDTH-1:0][TRACK_SEL_W-1:0] swbx_cfg_t;

    // one track select per block pin
    typedef logic [LUT_K-1:0][PIN_SEL_W-1:0] cx_cfg_t;

    // a truth table per element, indexed by the pins with pin 2 on top
    typedef logic [NUM_BLE-1:0][2**LUT_K-1:0] clb_cfg_t;

    // the io field sits at the low end because io_block is first in the chain
    typedef struct packed {
        clb_cfg_t  clb1;
        cx_cfg_t   cx1;
        clb_cfg_t  clb0;
        cx_cfg_t   cx0;
        swbx_cfg_t swbx;
        io_cfg_t   io;
    } fabric_cfg_t;

    localparam int CONFIG_BITS = $bits(fabric_cfg_t);

endpackage

// File: fabric_top.sv
`timescale 1ns/100ps

module fabric_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 config_en,
    input  logic                 config_in,
    output logic                 config_out,
    input  fabric_pkg::pad_vec_t data_in,
    output fabric_pkg::pad_vec_t data_out
);

    import fabric_pkg::*;

    // chain links, io then switch box then a connector box and clb pair per column
    logic [2*NUM_CLB+1:0]           chain;
    pad_vec_t                       pad_q;
    ble_vec_t                       ble_q;
    track_vec_t                     track;
    logic [NUM_CLB-1:0][LUT_K-1:0]  clb_in;

    io_block u_io (
        .clk       (clk),
        .reset     (reset),
        .config_en (config_en),
        .config_in (config_in),
        .config_out(chain[0]),
        .data_in   (data_in),
        .ble_q     (ble_q),
        .pad_q     (pad_q),
        .data_out  (data_out)
    );

    switch_box u_swbx (
        .clk       (clk),
        .reset     (reset),
        .config_en (config_en),
        .config_in (chain[0]),
        .config_out(chain[1]),
        .pad_q     (pad_q),
        .ble_q     (ble_q),
        .track     (track)
    );

    for (genvar i = 0; i < NUM_CLB; i++) begin : gen_clb
        connector_box u_cx (
            .clk       (clk),
            .reset     (reset),
            .config_en (config_en),
            .config_in (chain[2*i+1]),
            .config_out(chain[2*i+2]),
            .track     (track),
            .clb_in    (clb_in[i])
        );

        clb u_clb (
            .clk       (clk),
            .reset     (reset),
            .config_en (config_en),
            .config_in (chain[2*i+2]),
            .config_out(chain[2*i+3]),
            .clb_in    (clb_in[i]),
            .ble_q     (ble_q[i*NUM_BLE +: NUM_BLE])
        );
    end

    assign config_out = chain[2*NUM_CLB+1];   // last clb closes the chain

endmodule

// File: flist.f
fabric_pkg.sv
config_chain.sv
io_block.sv
switch_box.sv
connector_box.sv
clb.sv
fabric_top.sv
tb_fabric.sv

// File: io_block.sv
`timescale 1ns/100ps

module io_block (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 config_en,
    input  logic                 config_in,
    output logic                 config_out,
    input  fabric_pkg::pad_vec_t data_in,
    input  fabric_pkg::ble_vec_t ble_q,
    output fabric_pkg::pad_vec_t pad_q,
    output fabric_pkg::pad_vec_t data_out
);

    import fabric_pkg::*;

    io_cfg_t  cfg;
    pad_vec_t out_d;

    config_chain #(
        .cfg_t(io_cfg_t)
    ) u_chain (
        .clk       (clk),
        .reset     (reset),
        .config_en (config_en),
        .config_in (config_in),
        .config_out(config_out),
        .cfg       (cfg)
    );

    // each output pad picks one element output
    always_comb begin
        for (int o = 0; o < NUM_PAD_OUT; o++) begin
            out_d[o] = ble_q[cfg[o]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pad_q    <= '0;
            data_out <= '0;
        end else begin
            pad_q    <= data_in;   // input pads are sampled every cycle
            data_out <= out_d;
        end
    end

endmodule

// File: switch_box.sv
`timescale 1ns/100ps

module switch_box (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   config_en,
    input  logic                   config_in,
    output logic                   config_out,
    input  fabric_pkg::pad_vec_t   pad_q,
    input  fabric_pkg::ble_vec_t   ble_q,
    output fabric_pkg::track_vec_t track
);

    import fabric_pkg::*;

    swbx_cfg_t                cfg;
    logic [NUM_TRACK_SRC-1:0] src;

    config_chain #(
        .cfg_t(swbx_cfg_t)
    ) u_chain (
        .clk       (clk),
        .reset     (reset),
        .config_en (config_en),
        .config_in (config_in),
        .config_out(config_out),
        .cfg       (cfg)
    );

    // pads take sources 0 to 3 and element outputs follow them
    assign src = {ble_q, pad_q};

    // the tracks are pure muxes so a route costs no extra cycle
    always_comb begin
        for (int t = 0; t < CHAN_WIDTH; t++) begin
            track[t] = src[cfg[t]];
        end
    end

endmodule

// File: tb_fabric.sv
`timescale 1ns/100ps

module tb_fabric;

    import fabric_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 8;
    localparam int PASS_CYCLES  = 100;
    localparam int NUM_RAND_CFG = 4;
    localparam int RAND_CYCLES  = 200;
    localparam int MID_CYCLES   = 40;
    localparam int QUIET_CYCLES = 30;

    // four chain lengths are readback in and out, the pass-through load and the final drain
    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + 4 * CONFIG_BITS + PASS_CYCLES
        + NUM_RAND_CFG * (CONFIG_BITS + RAND_CYCLES) + MID_CYCLES + 1 + QUIET_CYCLES;
    localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * CLK_PERIOD;

    logic     clk;
    logic     reset;
    logic     config_en;
    logic     config_in;
    logic     config_out;
    pad_vec_t data_in;
    pad_vec_t data_out;
    integer   seed;

    // cycle model state
    fabric_cfg_t model_cfg;
    pad_vec_t    model_pad;
    ble_vec_t    model_ble;
    pad_vec_t    model_out;

    fabric_top UUT (
        .clk       (clk),
        .reset     (reset),
        .config_en (config_en),
        .config_in (config_in),
        .config_out(config_out),
        .data_in   (data_in),
        .data_out  (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // the upper half of the sources are element outputs
    function automatic logic pick_source(input logic [TRACK_SEL_W-1:0] sel,
                                         input pad_vec_t pad, input ble_vec_t ble);
        if (sel[TRACK_SEL_W-1]) begin
            return ble[sel[1:0]];
        end else begin
            return pad[sel[1:0]];
        end
    endfunction

    task automatic update_model();
        track_vec_t       trk;
        logic [LUT_K-1:0] pins0;
        logic [LUT_K-1:0] pins1;
        ble_vec_t         nxt_ble;
        pad_vec_t         nxt_out;
        if (reset) begin
            model_cfg = '0;
            model_pad = '0;
            model_ble = '0;
            model_out = '0;
        end else begin
            trk = {pick_source(model_cfg.swbx[3], model_pad, model_ble),
                   pick_source(model_cfg.swbx[2], model_pad, model_ble),
                   pick_source(model_cfg.swbx[1], model_pad, model_ble),
                   pick_source(model_cfg.swbx[0], model_pad, model_ble)};
            pins0 = {trk[model_cfg.cx0[2]], trk[model_cfg.cx0[1]], trk[model_cfg.cx0[0]]};
            pins1 = {trk[model_cfg.cx1[2]], trk[model_cfg.cx1[1]], trk[model_cfg.cx1[0]]};
            nxt_ble = {model_cfg.clb1[1][pins1], model_cfg.clb1[0][pins1],
                       model_cfg.clb0[1][pins0], model_cfg.clb0[0][pins0]};
            nxt_out = {model_ble[model_cfg.io[3]], model_ble[model_cfg.io[2]],
                       model_ble[model_cfg.io[1]], model_ble[model_cfg.io[0]]};
            model_pad = data_in;
            model_ble = nxt_ble;
            model_out = nxt_out;
            if (config_en) begin
                model_cfg = fabric_cfg_t'({model_cfg[CONFIG_BITS-2:0], config_in});
            end
        end
    endtask

    // one clock edge, then compare the DUT against the model once outputs settle
    task automatic step_cycle();
        @(posedge clk);
        update_model();
        #1;
        check_value("data_out", 64'(data_out), 64'(model_out));
        check_value("config_out", 64'(config_out), 64'(model_cfg[CONFIG_BITS-1]));
    endtask

    task automatic load_config(input fabric_cfg_t cfg);
        logic [CONFIG_BITS-1:0] bits;
        bits      = cfg;
        config_en = 1'b1;
        repeat (CONFIG_BITS) begin
            config_in = bits[CONFIG_BITS-1];   // msb goes in first
            data_in   = pad_vec_t'($random(seed));
            step_cycle();
            bits = {bits[CONFIG_BITS-2:0], 1'b0};
        end
        config_en = 1'b0;
        config_in = 1'b0;
    endtask

    task automatic run_random_data(input int cycles);
        repeat (cycles) begin
            data_in = pad_vec_t'($random(seed));
            step_cycle();
        end
    endtask

    initial begin
        fabric_cfg_t            cfg;
        logic [CONFIG_BITS-1:0] bits;
        pad_vec_t               hist[$];
        seed       = 79;
        reset      = 1'b1;
        config_en  = 1'b0;
        config_in  = 1'b0;
        data_in    = '0;
        model_cfg  = '0;
        model_pad  = '0;
        model_ble  = '0;
        model_out  = '0;
        repeat (RESET_CYCLES) step_cycle();
        reset = 1'b0;

        // an empty configuration keeps every output low
        repeat (IDLE_CYCLES) begin
            data_in = pad_vec_t'($random(seed));
            step_cycle();
            check_value("data_out", 64'(data_out), 64'd0);
            check_value("config_out", 64'(config_out), 64'd0);
        end

        cfg = fabric_cfg_t'({$random(seed), $random(seed)});
        load_config(cfg);
        bits      = cfg;
        config_en = 1'b1;
        config_in = 1'b0;
        repeat (CONFIG_BITS) begin
            check_value("config_out", 64'(config_out), 64'(bits[CONFIG_BITS-1]));
            data_in = pad_vec_t'($random(seed));
            step_cycle();
            bits = {bits[CONFIG_BITS-2:0], 1'b0};
        end
        config_en = 1'b0;

        // pad n reaches output n through element n, each table copying one pin
        cfg      = '0;
        cfg.swbx = {3'd3, 3'd2, 3'd1, 3'd0};
        cfg.cx0  = {2'd0, 2'd1, 2'd0};
        cfg.cx1  = {2'd2, 2'd3, 2'd2};
        cfg.clb0 = {8'hcc, 8'haa};
        cfg.clb1 = {8'hcc, 8'haa};
        cfg.io   = {2'd3, 2'd2, 2'd1, 2'd0};
        load_config(cfg);
        repeat (PASS_CYCLES) begin
            data_in = pad_vec_t'($random(seed));
            hist.push_back(data_in);
            step_cycle();
            if (hist.size() == 3) begin
                check_value("data_out", 64'(data_out), 64'(hist.pop_front()));
            end
        end

        for (int n = 0; n < NUM_RAND_CFG; n++) begin
            cfg = fabric_cfg_t'({$random(seed), $random(seed)});
            cfg.swbx[3] = {1'b1, cfg.swbx[3][1:0]};   // track 3 always feeds back an element
            load_config(cfg);
            run_random_data(RAND_CYCLES);
        end

        run_random_data(MID_CYCLES);
        reset   = 1'b1;
        data_in = pad_vec_t'($random(seed));
        step_cycle();
        reset = 1'b0;
        repeat (QUIET_CYCLES) begin
            data_in = pad_vec_t'($random(seed));
            step_cycle();
            check_value("data_out", 64'(data_out), 64'd0);
        end
        load_config('0);   // the drained chain must read back all zeros

        $display("Finished with no errors");
        $finish;
    end

endmodule
